// File: Bender.yml
package:
  name: gemm_stream

sources:
  - hdl/gemm_stream_pkg.sv
  - hdl/step_counter.sv
  - hdl/operand_addr_gen.sv
  - hdl/pair_issue.sv
  - hdl/gemm_stream_top.sv
  - target: test
    files:
      - dv/tb_gemm_stream.sv

// File: build.f
hdl/gemm_stream_pkg.sv
hdl/step_counter.sv
hdl/operand_addr_gen.sv
hdl/pair_issue.sv
hdl/gemm_stream_top.sv
dv/tb_gemm_stream.sv

// File: dv/tb_gemm_stream.sv
// Self-checking testbench for the operand streamer, simulate with tb_gemm_stream as top module
`timescale 1ns/1ps

module tb_gemm_stream import gemm_stream_pkg::*; ();

    localparam int PARALLELISM = 4;
    localparam int CREDITS     = 4;
    localparam int MAX_REQ     = 1024;
    localparam int MAX_TILES   = 16;
    localparam int WAIT_LIMIT  = 3000;

    logic       clk_i;
    logic       rst_i;
    logic       start_i;
    tile_desc_t desc_i;
    logic       req_valid_o;
    pair_req_t  req_o;
    logic       credit_i;
    logic       busy_o;
    logic       done_o;

    // Error counters and random seed
    int     value_errs;
    int     proto_errs;
    integer seed;

    // Expected pairs of all tiles in issue order
    pair_req_t exp_mem [MAX_REQ];
    // Request count at the end of each tile
    int        tile_end [MAX_TILES];
    int        exp_wr;
    int        req_idx;
    int        outstanding;
    int        done_cnt;
    int        tiles;
    int        cycle;

    // Memory model state
    logic hold_credits;
    int   credit_due[$];
    int   last_due;

    gemm_stream_top #(
        .PARALLELISM (PARALLELISM),
        .CREDITS     (CREDITS)
    ) dut (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .start_i     (start_i),
        .desc_i      (desc_i),
        .req_valid_o (req_valid_o),
        .req_o       (req_o),
        .credit_i    (credit_i),
        .busy_o      (busy_o),
        .done_o      (done_o)
    );

    initial clk_i = 1'b0;
    always #4 clk_i = ~clk_i;

    // Bookkeeping of issued requests, returned credits and done pulses
    always @(posedge clk_i) begin
        if (rst_i) begin
            cycle       <= 0;
            req_idx     <= 0;
            outstanding <= 0;
            done_cnt    <= 0;
        end else begin
            cycle       <= cycle + 1;
            outstanding <= outstanding + int'(req_valid_o) - int'(credit_i);
            if (req_valid_o) req_idx <= req_idx + 1;
            if (done_o) done_cnt <= done_cnt + 1;
        end
    end

    // Memory schedules one credit per request, returns stay in order
    always @(posedge clk_i) begin
        int delay;
        int due;
        if (rst_i) begin
            credit_due.delete();
            last_due = 0;
        end else if (req_valid_o) begin
            delay = $unsigned($random(seed)) % 6;
            // Now and then a long stall
            if ($unsigned($random(seed)) % 10 == 0) delay = delay + 40;
            due = cycle + 1 + delay;
            if (due <= last_due) due = last_due + 1;
            credit_due.push_back(due);
            last_due = due;
        end
    end

    // At most one credit pulse per cycle
    always @(negedge clk_i) begin
        credit_i = 1'b0;
        if (!rst_i && !hold_credits && credit_due.size() > 0 && credit_due[0] <= cycle) begin
            void'(credit_due.pop_front());
            credit_i = 1'b1;
        end
    end

    // Outputs idle right after reset
    ap_reset_idle: assert property (@(posedge clk_i)
        rst_i |=> (!req_valid_o && !busy_o && !done_o)
    ) else begin
        value_errs++;
        $display("FAIL %0t req_valid_o,busy_o,done_o got %b%b%b expected 000", $time,
                 $sampled(req_valid_o), $sampled(busy_o), $sampled(done_o));
    end

    ap_req_pending: assert property (@(posedge clk_i) disable iff (rst_i)
        req_valid_o |-> (req_idx < exp_wr)
    ) else begin
        proto_errs++;
        $display("Request issued at %0t with no expected pair left", $time);
    end

    ap_a_addr: assert property (@(posedge clk_i) disable iff (rst_i)
        req_valid_o |-> (req_o.a_addr == exp_mem[req_idx].a_addr)
    ) else begin
        value_errs++;
        $display("FAIL %0t req_o.a_addr got %h expected %h", $time,
                 $sampled(req_o.a_addr), exp_mem[$sampled(req_idx)].a_addr);
    end

    ap_b_addr: assert property (@(posedge clk_i) disable iff (rst_i)
        req_valid_o |-> (req_o.b_addr == exp_mem[req_idx].b_addr)
    ) else begin
        value_errs++;
        $display("FAIL %0t req_o.b_addr got %h expected %h", $time,
                 $sampled(req_o.b_addr), exp_mem[$sampled(req_idx)].b_addr);
    end

    // Done right after the final request of the tile, never early
    // Next tile may already be queued here, so compare against this tile's end
    ap_done_after_last: assert property (@(posedge clk_i) disable iff (rst_i)
        done_o |-> ($past(req_valid_o) && req_idx == tile_end[done_cnt])
    ) else begin
        value_errs++;
        $display("FAIL %0t requests_at_done got %0d expected %0d", $time,
                 $sampled(req_idx), tile_end[$sampled(done_cnt)]);
    end

    ap_done_pulse: assert property (@(posedge clk_i) disable iff (rst_i)
        done_o |=> !done_o
    ) else begin
        proto_errs++;
        $display("done_o held high for more than one cycle at %0t", $time);
    end

    ap_busy_drop: assert property (@(posedge clk_i) disable iff (rst_i)
        done_o |-> !busy_o
    ) else begin
        value_errs++;
        $display("FAIL %0t busy_o got %b expected 0", $time, $sampled(busy_o));
    end

    ap_credit_limit: assert property (@(posedge clk_i) disable iff (rst_i)
        outstanding <= CREDITS
    ) else begin
        value_errs++;
        $display("FAIL %0t outstanding got %0d expected at most %0d", $time,
                 $sampled(outstanding), CREDITS);
    end

    // Closing report
    task automatic finish_run();
        $display("Value errors: %0d, other errors: %0d", value_errs, proto_errs);
        if (value_errs + proto_errs == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    endtask

    // Reference loop nest, appends the pairs of one tile
    task automatic add_expected(input tile_desc_t d);
        addr_t a_row;
        addr_t b_row;
        int    o;
        int    k;
        for (o = 0; o < int'(d.outer_len); o++) begin
            a_row = d.a_cfg.base + addr_t'(o) * d.a_cfg.outer_stride;
            b_row = d.b_cfg.base + addr_t'(o) * d.b_cfg.outer_stride;
            for (k = 0; k < int'(d.k_len); k += PARALLELISM) begin
                exp_mem[exp_wr].a_addr = a_row + addr_t'(k) * addr_t'(ELEM_BYTES);
                exp_mem[exp_wr].b_addr = b_row + addr_t'(k) * addr_t'(ELEM_BYTES);
                exp_wr++;
            end
        end
        // One past the final pair of this tile
        tile_end[tiles] = exp_wr;
    endtask

    function automatic tile_desc_t make_desc(input cnt_t outer, input cnt_t k,
                                             input addr_t a_base, input addr_t a_stride,
                                             input addr_t b_base, input addr_t b_stride);
        tile_desc_t d;
        d.outer_len           = outer;
        d.k_len               = k;
        d.a_cfg.base          = a_base;
        d.a_cfg.outer_stride  = a_stride;
        d.b_cfg.base          = b_base;
        d.b_cfg.outer_stride  = b_stride;
        return d;
    endfunction

    task automatic wait_done();
        int n;
        n = 0;
        while (!done_o) begin
            @(negedge clk_i);
            n++;
            if (n > WAIT_LIMIT) begin
                proto_errs++;
                $display("Timeout waiting for done_o at %0t", $time);
                finish_run();
            end
        end
    endtask

    // Memory holds credits until a full burst is out
    task automatic wait_burst();
        int n;
        n = 0;
        while (outstanding < CREDITS) begin
            @(negedge clk_i);
            n++;
            if (n > WAIT_LIMIT) begin
                proto_errs++;
                $display("Timeout waiting for a full burst of requests");
                finish_run();
            end
        end
        // Stay stalled a while so any extra request would show
        repeat (12) @(negedge clk_i);
        hold_credits = 1'b0;
    endtask

    task automatic run_tile(input tile_desc_t d, input bit burst, input bit poke);
        tile_desc_t other;
        add_expected(d);
        hold_credits = burst;
        desc_i       = d;
        start_i      = 1'b1;
        @(negedge clk_i);
        start_i = 1'b0;
        if (burst) wait_burst();
        if (poke) begin
            repeat (2) @(negedge clk_i);
            if (!busy_o) begin
                value_errs++;
                $display("FAIL %0t busy_o got %b expected 1", $time, busy_o);
            end
            // Different tile offered while busy, must be ignored
            other = make_desc(16'd7, 16'd8, 32'hdead_0000, 32'h10, 32'hbeef_0000, 32'h20);
            desc_i  = other;
            start_i = 1'b1;
            @(negedge clk_i);
            start_i = 1'b0;
        end
        wait_done();
        tiles++;
    endtask

    initial begin
        tile_desc_t  d;
        logic [31:0] r;
        int          i;
        seed         = 32'hc793a5cb;
        rst_i        = 1'b1;
        start_i      = 1'b0;
        credit_i     = 1'b0;
        desc_i       = '0;
        hold_credits = 1'b0;
        exp_wr       = 0;
        tiles        = 0;
        value_errs   = 0;
        proto_errs   = 0;
        repeat (2) @(negedge clk_i);
        rst_i = 1'b0;
        repeat (2) @(negedge clk_i);

        run_tile(make_desc(16'd3, 16'd8, 32'h1000, 32'h40, 32'h8000, 32'h100), 1'b1, 1'b0);
        run_tile(make_desc(16'd5, 16'd16, 32'h0, 32'h20, 32'h2_0000, 32'h200), 1'b0, 1'b1);
        // Back to back, start in the done cycle
        run_tile(make_desc(16'd1, 16'd4, 32'hffff_fff0, 32'h8, 32'h44, 32'h4), 1'b0, 1'b0);
        run_tile(make_desc(16'd4, 16'd12, 32'h3, 32'h13, 32'h7ff1, 32'h1000), 1'b0, 1'b0);

        for (i = 0; i < 3; i++) begin
            r = $random(seed);
            d = make_desc(cnt_t'(1 + r[2:0] % 5), cnt_t'(PARALLELISM * (1 + r[5:4])),
                          $random(seed), $random(seed) & 32'hffff,
                          $random(seed), $random(seed) & 32'hffff);
            run_tile(d, 1'b0, 1'b0);
        end

        repeat (4) @(negedge clk_i);
        if (done_cnt != tiles) begin
            value_errs++;
            $display("FAIL %0t done_pulses got %0d expected %0d", $time, done_cnt, tiles);
        end
        if (req_idx != exp_wr) begin
            value_errs++;
            $display("FAIL %0t requests got %0d expected %0d", $time, req_idx, exp_wr);
        end
        finish_run();
    end

endmodule

// File: hdl/gemm_stream_pkg.sv
// Shared types and constants for the GEMM operand streamer, imported by every RTL module
package gemm_stream_pkg;

    // Byte address in operand memory
    typedef logic [31:0] addr_t;

    // Loop count or loop index
    typedef logic [15:0] cnt_t;

    // Size of one operand element in bytes
    // Generators scale the inner loop index by this value
    localparam int unsigned ELEM_BYTES = 1;

    // Address pattern of one operand
    typedef struct packed {
        // Address of the first element of the tile
        addr_t base;
        // Bytes between the starts of two consecutive rows
        addr_t outer_stride;
    } operand_cfg_t;

    // One tile job as handed over by the host
    typedef struct packed {
        // Number of rows in the outer loop, nonzero
        cnt_t         outer_len;
        // Reduction length, nonzero multiple of PARALLELISM
        cnt_t         k_len;
        // A operand pattern
        operand_cfg_t a_cfg;
        // B operand pattern
        operand_cfg_t b_cfg;
    } tile_desc_t;

    // Paired request sent to operand memory
    typedef struct packed {
        addr_t a_addr;
        addr_t b_addr;
    } pair_req_t;

endpackage

// File: hdl/gemm_stream_top.sv
// Top level of the operand streamer, takes a tile descriptor and issues paired memory requests
`timescale 1ns/1ps

module gemm_stream_top import gemm_stream_pkg::*; #(
    parameter int PARALLELISM = 4,
    parameter int CREDITS     = 4
) (
    input  logic       clk_i,
    input  logic       rst_i,
    input  logic       start_i,
    input  tile_desc_t desc_i,
    output logic       req_valid_o,
    output pair_req_t  req_o,
    input  logic       credit_i,
    output logic       busy_o,
    output logic       done_o
);

    logic busy_q;
    logic start_acc;

    // Operand patterns held for the whole tile
    operand_cfg_t a_cfg_q;
    operand_cfg_t b_cfg_q;

    // Generator streams
    logic  a_valid;
    addr_t a_addr;
    logic  a_last;
    logic  b_valid;
    addr_t b_addr;
    logic  b_last;
    logic  ready;

    // Start while busy is dropped
    assign start_acc = start_i & ~busy_o;

    // Busy drops in the done cycle so a new start can follow at once
    assign busy_o = busy_q & ~done_o;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            busy_q <= 1'b0;
        end else if (start_acc) begin
            busy_q <= 1'b1;
        end else if (done_o) begin
            busy_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (start_acc) begin
            a_cfg_q <= desc_i.a_cfg;
            b_cfg_q <= desc_i.b_cfg;
        end
    end

    // Loop lengths go straight in, the counters latch them at start
    operand_addr_gen #(
        .PARALLELISM (PARALLELISM)
    ) gen_a (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .start_i     (start_acc),
        .outer_len_i (desc_i.outer_len),
        .k_len_i     (desc_i.k_len),
        .cfg_i       (a_cfg_q),
        .valid_o     (a_valid),
        .ready_i     (ready),
        .addr_o      (a_addr),
        .last_o      (a_last)
    );

    operand_addr_gen #(
        .PARALLELISM (PARALLELISM)
    ) gen_b (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .start_i     (start_acc),
        .outer_len_i (desc_i.outer_len),
        .k_len_i     (desc_i.k_len),
        .cfg_i       (b_cfg_q),
        .valid_o     (b_valid),
        .ready_i     (ready),
        .addr_o      (b_addr),
        .last_o      (b_last)
    );

    pair_issue #(
        .CREDITS (CREDITS)
    ) u_pair_issue (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .a_valid_i   (a_valid),
        .a_addr_i    (a_addr),
        .a_last_i    (a_last),
        .b_valid_i   (b_valid),
        .b_addr_i    (b_addr),
        .b_last_i    (b_last),
        .ready_o     (ready),
        .credit_i    (credit_i),
        .req_valid_o (req_valid_o),
        .req_o       (req_o),
        .done_o      (done_o)
    );

endmodule

// File: hdl/operand_addr_gen.sv
// Operand address generator walking an outer row loop and an inner reduction loop per handshake
`timescale 1ns/1ps

module operand_addr_gen import gemm_stream_pkg::*; #(
    parameter int PARALLELISM = 4
) (
    input  logic         clk_i,
    input  logic         rst_i,
    input  logic         start_i,
    input  cnt_t         outer_len_i,
    input  cnt_t         k_len_i,
    input  operand_cfg_t cfg_i,
    output logic         valid_o,
    input  logic         ready_i,
    output addr_t        addr_o,
    output logic         last_o
);

    typedef enum logic {
        IDLE,
        RUN
    } state_e;

    state_e state_q;
    state_e state_d;

    // Loop indices and flags of both levels
    cnt_t inner_q;
    cnt_t outer_q;
    logic inner_last;
    logic outer_last;
    logic outer_wrapped;

    // Handshake and loop control
    logic take;
    logic inner_clear;
    logic outer_step;

    assign take = valid_o & ready_i;

    // End of a row that is not the final one restarts the inner loop
    assign inner_clear = take & inner_last & ~outer_last;
    // Inner wrap advances the row in the same cycle
    assign outer_step  = take & inner_last;

    // Inner reduction loop, PARALLELISM elements per address
    step_counter #(
        .STEP (PARALLELISM)
    ) u_inner (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .load_i    (start_i),
        .target_i  (k_len_i - cnt_t'(1)),
        .step_i    (take),
        .clear_i   (inner_clear),
        .q_o       (inner_q),
        .last_o    (inner_last),
        .wrapped_o ()
    );

    // Outer row loop
    step_counter #(
        .STEP (1)
    ) u_outer (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .load_i    (start_i),
        .target_i  (outer_len_i - cnt_t'(1)),
        .step_i    (outer_step),
        .clear_i   (1'b0),
        .q_o       (outer_q),
        .last_o    (outer_last),
        .wrapped_o (outer_wrapped)
    );

    // FSM, the outer wrap marks the end of the tile
    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: if (start_i) state_d = RUN;
            RUN:  if (outer_wrapped) state_d = IDLE;
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Drop valid right after the final handshake
    assign valid_o = (state_q == RUN) & ~outer_wrapped;

    // base + row * stride + element * size
    assign addr_o = cfg_i.base
                  + addr_t'(outer_q) * cfg_i.outer_stride
                  + addr_t'(inner_q) * addr_t'(ELEM_BYTES);

    assign last_o = inner_last & outer_last;

    // Stalled address must not move
    ap_addr_hold: assert property (
        @(posedge clk_i) disable iff (rst_i)
        (valid_o && !ready_i) |=> (valid_o && $stable(addr_o))
    ) else $error("operand_addr_gen: address changed under stall");

endmodule

// File: hdl/pair_issue.sv
// Pairs the A and B address streams and issues them to memory against a credit counter
`timescale 1ns/1ps

module pair_issue import gemm_stream_pkg::*; #(
    parameter int CREDITS = 4
) (
    input  logic      clk_i,
    input  logic      rst_i,
    input  logic      a_valid_i,
    input  addr_t     a_addr_i,
    input  logic      a_last_i,
    input  logic      b_valid_i,
    input  addr_t     b_addr_i,
    input  logic      b_last_i,
    output logic      ready_o,
    input  logic      credit_i,
    output logic      req_valid_o,
    output pair_req_t req_o,
    output logic      done_o
);

    // One spare bit so an unexpected extra credit is visible
    localparam int CW = $clog2(CREDITS + 1) + 1;

    logic [CW-1:0] credit_q;
    logic          has_credit;
    logic          take;

    // Output register
    logic      req_valid_q;
    pair_req_t req_q;
    logic      req_last_q;
    logic      done_q;

    assign has_credit = (credit_q != '0);

    // Join both streams, a pair moves only with a credit in hand
    assign ready_o = has_credit & a_valid_i & b_valid_i;
    assign take    = ready_o;

    // Credit count
    // One credit spent per issue, one returned per credit_i pulse
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            credit_q <= CW'(CREDITS);
        end else begin
            case ({take, credit_i})
                2'b10:   credit_q <= credit_q - CW'(1);
                2'b01:   credit_q <= credit_q + CW'(1);
                default: credit_q <= credit_q;
            endcase
        end
    end

    // Request valid and last marker
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            req_valid_q <= 1'b0;
            req_last_q  <= 1'b0;
        end else begin
            req_valid_q <= take;
            req_last_q  <= take & a_last_i;
        end
    end

    // Request payload, loaded only on a taken pair
    always_ff @(posedge clk_i) begin
        if (take) begin
            req_q.a_addr <= a_addr_i;
            req_q.b_addr <= b_addr_i;
        end
    end

    // Done one cycle after the final request leaves
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            done_q <= 1'b0;
        end else begin
            done_q <= req_valid_q & req_last_q;
        end
    end

    assign req_valid_o = req_valid_q;
    assign req_o       = req_q;
    assign done_o      = done_q;

    // Memory must not return more credits than were handed out
    ap_credit_max: assert property (
        @(posedge clk_i) disable iff (rst_i)
        credit_q <= CW'(CREDITS)
    ) else $error("pair_issue: credit count above CREDITS");

    // Both generators must reach their final address on the same pair
    ap_last_match: assert property (
        @(posedge clk_i) disable iff (rst_i)
        take |-> (a_last_i == b_last_i)
    ) else $error("pair_issue: A and B last flags differ");

endmodule

// File: hdl/step_counter.sv
// Loadable step counter with last and sticky wrap flags, used as one loop level of a generator
`timescale 1ns/1ps

module step_counter import gemm_stream_pkg::*; #(
    parameter int STEP = 4
) (
    input  logic clk_i,
    input  logic rst_i,
    input  logic load_i,
    input  cnt_t target_i,
    input  logic step_i,
    input  logic clear_i,
    output cnt_t q_o,
    output logic last_o,
    output logic wrapped_o
);

    // Loaded target, count and sticky wrap flag
    cnt_t target_q;
    cnt_t count_q;
    logic wrapped_q;

    // Count value of the final step before wrap
    cnt_t last_val;
    logic at_last;

    assign last_val = target_q - cnt_t'(STEP) + cnt_t'(1);
    assign at_last  = (count_q == last_val);

    assign q_o       = count_q;
    assign last_o    = at_last & ~wrapped_q;
    assign wrapped_o = wrapped_q;

    // Target register
    // Reset to all ones so last_o stays low until a real load
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            target_q <= '1;
        end else if (load_i) begin
            target_q <= target_i;
        end
    end

    // Count and wrap flag
    // Priority is load, then clear, then step
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            count_q   <= '0;
            wrapped_q <= 1'b0;
        end else if (load_i || clear_i) begin
            count_q   <= '0;
            wrapped_q <= 1'b0;
        end else if (step_i) begin
            if (at_last) begin
                // Wrap back to the start, flag stays until reload
                count_q   <= '0;
                wrapped_q <= 1'b1;
            end else begin
                count_q <= count_q + cnt_t'(STEP);
            end
        end
    end

    // Once wrapped, the owner must reload or clear before stepping again
    ap_no_step_after_wrap: assert property (
        @(posedge clk_i) disable iff (rst_i)
        !(step_i && wrapped_o)
    ) else $error("step_counter: step while wrapped");

endmodule
